// ==== Makefile ====
# Verilator build and run of the debug overlay testbench

VERILATOR ?= verilator
TOP       ?= tb_debug_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell cat $(FILELIST))
EXE  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(EXE)
	./$(EXE) $(SIM_ARGS) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== debug_chk.sv ====
////////////////////////////////////////////////////////////////////////////
// key decoder assertions, bound into every debug_top instance
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module debug_chk import debug_key_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      ctrl,
    input logic      debug_plus,
    input logic      debug_minus,
    input gfx_en_t   key_gfx,
    input gfx_en_t   gfx_en,
    input dbg_byte_t debug_bus
);

    int fail_cnt = 0;  // assertion failures so far

    // a layer bit flips only after its own key went high
    a_gfx_toggle: assert property (@(posedge clk) disable iff (rst)
        ((gfx_en ^ $past(gfx_en)) & ~($past(key_gfx) & ~$past(key_gfx, 2))) == '0)
    else begin
        $error("gfx_en changed without a key_gfx rising edge");
        fail_cnt++;
    end

    a_bus_clear: assert property (@(posedge clk) disable iff (rst)
        (ctrl && (debug_plus || debug_minus)) |=> (debug_bus == '0))
    else begin
        $error("debug_bus not cleared after ctrl with plus or minus");
        fail_cnt++;
    end

endmodule

bind debug_top debug_chk u_chk (
    .clk (clk), .rst (rst), .ctrl (ctrl), .debug_plus (debug_plus),
    .debug_minus (debug_minus), .key_gfx (key_gfx), .gfx_en (gfx_en),
    .debug_bus (debug_bus)
);

`default_nettype wire

// ==== debug_font.sv ====
////////////////////////////////////////////////////////////////////////////
// 4x5 hex glyph ROM, combinational; pixel 0 is top-left, rows of 4
// pixel indices of 20 and above read as 0
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module debug_font (
    input  logic [3:0] glyph,
    input  logic [4:0] pix,
    output logic       bit_out
);

    logic [19:0] rows;  // top row in bits 19:16

    always_comb begin
        case (glyph)
            4'h0: rows = 20'b0110_1001_1001_1001_0110;
            4'h1: rows = 20'b0010_0110_0010_0010_0111;
            4'h2: rows = 20'b1110_0001_0110_1000_1111;
            4'h3: rows = 20'b1111_0001_0110_0001_1110;
            4'h4: rows = 20'b0010_1010_1010_1111_0010;
            4'h5: rows = 20'b1111_1000_1110_0001_1110;
            4'h6: rows = 20'b0110_1000_1110_1001_0110;
            4'h7: rows = 20'b1111_0001_0010_0100_0100;
            4'h8: rows = 20'b0110_1001_0110_1001_0110;
            4'h9: rows = 20'b0110_1001_0111_0001_0110;
            4'hA: rows = 20'b0110_1001_1001_1111_1001;
            4'hB: rows = 20'b1110_1001_1110_1001_1110;
            4'hC: rows = 20'b0111_1000_1000_1000_0111;
            4'hD: rows = 20'b1110_1001_1001_1001_1110;
            4'hE: rows = 20'b1111_1000_1110_1000_1111;
            default: rows = 20'b1111_1000_1110_1000_1000;  // F
        endcase
    end

    // MSB-first read, guarded against indices past the glyph
    assign bit_out = (pix < 5'd20) ? rows[5'd19 - pix] : 1'b0;

endmodule

`default_nettype wire

// ==== debug_key_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// key side types and step sizes of the debug overlay
// step arithmetic wraps modulo 256 on the 8-bit debug bus
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package debug_key_pkg;

    // debug bus, view byte, debug_view and sys_info
    typedef logic [7:0] dbg_byte_t;

    // one bit per graphics layer
    typedef logic [3:0] gfx_en_t;

    // digit key strobes, bit 0 maps onto bus bit 7
    typedef logic [7:0] key_digit_t;

    localparam dbg_byte_t STEP_FINE   = 8'd1;   // plain plus/minus
    localparam dbg_byte_t STEP_COARSE = 8'd16;  // with shift held

endpackage

`default_nettype wire

// ==== debug_keys.sv ====
////////////////////////////////////////////////////////////////////////////
// key decoder: keys are levels sampled on clk, each rising level acts once
// clear (ctrl with plus or minus) wins over steps and digit XOR
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module debug_keys import debug_key_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       shift,
    input  logic       ctrl,
    input  logic       debug_plus,
    input  logic       debug_minus,
    input  gfx_en_t    key_gfx,
    input  key_digit_t key_digit,
    input  dbg_byte_t  debug_view,
    input  dbg_byte_t  sys_info,
    output dbg_byte_t  debug_bus,
    output gfx_en_t    gfx_en,
    output logic       view_sel,
    output dbg_byte_t  view_val
);

    logic      last_plus, last_minus, last_digit, last_vtog;
    gfx_en_t   last_gfx;
    dbg_byte_t step;
    dbg_byte_t digit_rev;
    logic      plus_rise, minus_rise, digit_rise, vtog_rise;
    logic      clear_bus;

    assign step       = shift ? STEP_COARSE : STEP_FINE;
    assign plus_rise  = debug_plus & ~last_plus;
    assign minus_rise = debug_minus & ~last_minus;
    assign digit_rise = (|key_digit) & ~last_digit;  // any digit key going down
    assign vtog_rise  = (shift & ctrl) & ~last_vtog;
    assign clear_bus  = ctrl & (debug_plus | debug_minus);

    // digit key 0 lands on the bus MSB
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            digit_rev[i] = key_digit[7-i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_plus  <= 1'b0;
            last_minus <= 1'b0;
            last_digit <= 1'b0;
            last_vtog  <= 1'b0;
            last_gfx   <= '0;
            debug_bus  <= '0;
            gfx_en     <= '1;    // all layers on
            view_sel   <= 1'b0;
            view_val   <= '0;
        end else begin
            last_plus  <= debug_plus;
            last_minus <= debug_minus;
            last_digit <= |key_digit;
            last_vtog  <= shift & ctrl;
            last_gfx   <= key_gfx;

            if (clear_bus) begin
                debug_bus <= '0;
            end else if (shift && digit_rise) begin
                debug_bus <= debug_bus ^ digit_rev;  // beats a step in the same cycle
            end else if (plus_rise) begin
                debug_bus <= debug_bus + step;
            end else if (minus_rise) begin
                debug_bus <= debug_bus - step;
            end

            gfx_en <= gfx_en ^ (key_gfx & ~last_gfx);  // per-layer toggle

            if (vtog_rise) view_sel <= ~view_sel;
            view_val <= view_sel ? sys_info : debug_view;  // one cycle behind view_sel
        end
    end

endmodule

`default_nettype wire

// ==== debug_overlay.sv ====
////////////////////////////////////////////////////////////////////////////
// purely combinational overlay mixer; COLORW must be at least 2
// bus bit row sets all colour bits and the other areas only the top two
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module debug_overlay import debug_key_pkg::*, debug_video_pkg::*; #(
    parameter int COLORW = 4
) (
    input  logic [COLORW-1:0] rin,
    input  logic [COLORW-1:0] gin,
    input  logic [COLORW-1:0] bin,
    input  raster_cnt_t       hcnt,
    input  raster_cnt_t       vcnt,
    input  dbg_byte_t         debug_bus,
    input  dbg_byte_t         view_val,
    input  logic              bits_bus_on,
    input  logic              bits_view_on,
    input  logic              hex_bus_on,
    input  logic              hex_view_on,
    output logic [COLORW-1:0] rout,
    output logic [COLORW-1:0] gout,
    output logic [COLORW-1:0] bout
);

    logic [2:0] bit_idx;
    logic       bus_bit, view_bit;
    logic [3:0] bus_nib, view_nib;
    logic       cell_on, glyph_on;
    logic [2:0] glyph_row;
    logic [1:0] glyph_col;
    logic [4:0] font_pix;
    logic       fnt_bus_bit, fnt_view_bit, fnt_bus_hex, fnt_view_hex;
    logic       px_bus_bits, px_view_bits, px_bus_hex, px_view_hex;

    assign bit_idx  = ~hcnt[5:3];  // leftmost cell shows bit 7
    assign bus_bit  = debug_bus[bit_idx];
    assign view_bit = view_val[bit_idx];
    assign bus_nib  = hcnt[3] ? debug_bus[3:0] : debug_bus[7:4];
    assign view_nib = hcnt[3] ? view_val[3:0] : view_val[7:4];

    // column 0 of every cell is a gap
    assign cell_on  = hcnt[2:0] != 3'd0;
    // glyph box spans columns 3..6 and lines 2..6 of the cell
    assign glyph_on = (hcnt[2:0] >= 3'd3) && (hcnt[2:0] < 3'd7) &&
                      (vcnt[2:0] >= 3'd2) && (vcnt[2:0] < 3'd7);

    assign glyph_row = vcnt[2:0] - 3'd2;
    assign glyph_col = hcnt[1:0] - 2'd3;
    assign font_pix  = {glyph_row, 2'b00} + {3'b000, glyph_col};

    debug_font u_font_bus_bit (
        .glyph   ({3'b000, bus_bit}),
        .pix     (font_pix),
        .bit_out (fnt_bus_bit)
    );

    debug_font u_font_view_bit (
        .glyph   ({3'b000, view_bit}),
        .pix     (font_pix),
        .bit_out (fnt_view_bit)
    );

    debug_font u_font_bus_hex (
        .glyph   (bus_nib),
        .pix     (font_pix),
        .bit_out (fnt_bus_hex)
    );

    debug_font u_font_view_hex (
        .glyph   (view_nib),
        .pix     (font_pix),
        .bit_out (fnt_view_hex)
    );

    // bit cells show a solid level with the digit inverted against it
    assign px_bus_bits  = glyph_on ? (fnt_bus_bit ^ bus_bit) : bus_bit;
    assign px_view_bits = glyph_on ? (fnt_view_bit ^ view_bit) : view_bit;
    // hex digits drawn dark on a bright background
    assign px_bus_hex   = glyph_on ? ~fnt_bus_hex : 1'b1;
    assign px_view_hex  = glyph_on ? ~fnt_view_hex : 1'b1;

    always_comb begin
        rout = rin;
        gout = gin;
        bout = bin;
        if (bits_bus_on && cell_on) begin
            rout = {COLORW{px_bus_bits}};
            gout = {COLORW{px_bus_bits}};
            bout = {COLORW{px_bus_bits}};
        end
        if (bits_view_on && cell_on) begin
            rout[COLORW-1 -: 2] = {2{px_view_bits}};
            gout[COLORW-1 -: 2] = {2{px_view_bits}};
            bout[COLORW-1 -: 2] = {2{px_view_bits}};
        end
        if (hex_bus_on && cell_on) begin
            rout[COLORW-1 -: 2] = {2{px_bus_hex}};
            gout[COLORW-1 -: 2] = {2{px_bus_hex}};
            bout[COLORW-1 -: 2] = {2{px_bus_hex}};
        end
        if (hex_view_on && cell_on) begin  // last one wins
            rout[COLORW-1 -: 2] = {2{px_view_hex}};
            gout[COLORW-1 -: 2] = {2{px_view_hex}};
            bout[COLORW-1 -: 2] = {2{px_view_hex}};
        end
    end

endmodule

`default_nettype wire

// ==== debug_raster.sv ====
////////////////////////////////////////////////////////////////////////////
// beam counters advance only on pxl_cen; no reset, they settle in blanking
// area flags are registered, so they lag the counters by one pixel
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module debug_raster import debug_key_pkg::*, debug_video_pkg::*; (
    input  logic        clk,
    input  logic        pxl_cen,
    input  logic        lhbl,
    input  logic        lvbl,
    input  dbg_byte_t   debug_bus,
    input  dbg_byte_t   view_val,
    input  logic        view_sel,
    output raster_cnt_t hcnt,
    output raster_cnt_t vcnt,
    output logic        bits_bus_on,
    output logic        bits_view_on,
    output logic        hex_bus_on,
    output logic        hex_view_on
);

    logic lhbl_l;
    logic row_bus, row_view;
    logic col_bits, col_hex;

    assign row_bus  = vcnt[8:3] == ROW_BUS;
    assign row_view = vcnt[8:3] == ROW_VIEW;
    assign col_bits = hcnt[8:6] == COL_BITS;
    assign col_hex  = hcnt[8:4] == COL_HEX;

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            lhbl_l <= lhbl;

            if (!lvbl)
                vcnt <= '0;
            else if (lhbl && !lhbl_l)
                vcnt <= vcnt + raster_cnt_t'(1);  // new active line

            if (!lhbl)
                hcnt <= '0;
            else
                hcnt <= hcnt + raster_cnt_t'(1);

            // nothing drawn for a zero value
            bits_bus_on  <= (debug_bus != '0) && row_bus && col_bits;
            bits_view_on <= (view_val != '0) && row_view && col_bits;
            hex_bus_on   <= (debug_bus != '0) && row_bus && col_hex;
            // sys_info view always shows its hex, even at zero
            hex_view_on  <= ((view_val != '0) || view_sel) && row_view && col_hex;
        end
    end

endmodule

`default_nettype wire

// ==== debug_top.sv ====
////////////////////////////////////////////////////////////////////////////
// debug overlay top: key decoder, raster tracker and colour mixer
// colour outputs are combinational from the game colours
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module debug_top import debug_key_pkg::*, debug_video_pkg::*; #(
    parameter int COLORW = 4   // at least 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              shift,
    input  logic              ctrl,
    input  logic              debug_plus,
    input  logic              debug_minus,
    input  gfx_en_t           key_gfx,
    input  key_digit_t        key_digit,
    input  logic              pxl_cen,
    input  logic [COLORW-1:0] rin,
    input  logic [COLORW-1:0] gin,
    input  logic [COLORW-1:0] bin,
    input  logic              lhbl,
    input  logic              lvbl,
    output logic [COLORW-1:0] rout,
    output logic [COLORW-1:0] gout,
    output logic [COLORW-1:0] bout,
    output dbg_byte_t         debug_bus,
    input  dbg_byte_t         debug_view,
    input  dbg_byte_t         sys_info,
    output gfx_en_t           gfx_en
);

    logic        view_sel;
    dbg_byte_t   view_val;
    raster_cnt_t hcnt, vcnt;
    logic        bits_bus_on, bits_view_on, hex_bus_on, hex_view_on;

    debug_keys u_keys (
        .clk         (clk),
        .rst         (rst),
        .shift       (shift),
        .ctrl        (ctrl),
        .debug_plus  (debug_plus),
        .debug_minus (debug_minus),
        .key_gfx     (key_gfx),
        .key_digit   (key_digit),
        .debug_view  (debug_view),
        .sys_info    (sys_info),
        .debug_bus   (debug_bus),
        .gfx_en      (gfx_en),
        .view_sel    (view_sel),
        .view_val    (view_val)
    );

    debug_raster u_raster (
        .clk          (clk),
        .pxl_cen      (pxl_cen),
        .lhbl         (lhbl),
        .lvbl         (lvbl),
        .debug_bus    (debug_bus),
        .view_val     (view_val),
        .view_sel     (view_sel),
        .hcnt         (hcnt),
        .vcnt         (vcnt),
        .bits_bus_on  (bits_bus_on),
        .bits_view_on (bits_view_on),
        .hex_bus_on   (hex_bus_on),
        .hex_view_on  (hex_view_on)
    );

    debug_overlay #(
        .COLORW (COLORW)
    ) u_overlay (
        .rin          (rin),
        .gin          (gin),
        .bin          (bin),
        .hcnt         (hcnt),
        .vcnt         (vcnt),
        .debug_bus    (debug_bus),
        .view_val     (view_val),
        .bits_bus_on  (bits_bus_on),
        .bits_view_on (bits_view_on),
        .hex_bus_on   (hex_bus_on),
        .hex_view_on  (hex_view_on),
        .rout         (rout),
        .gout         (gout),
        .bout         (bout)
    );

endmodule

`default_nettype wire

// ==== debug_video_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// raster counter type and the fixed screen positions of the overlay
// positions assume a 9-bit raster with 8-line character rows
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package debug_video_pkg;

    // horizontal and vertical beam counters
    typedef logic [8:0] raster_cnt_t;

    // line groups, compared against vcnt[8:3]
    localparam logic [5:0] ROW_BUS  = 6'h18;  // lines 192..199
    localparam logic [5:0] ROW_VIEW = 6'h1A;  // lines 208..215

    // bit cells span pixels 128..191, eight cells of 8 pixels
    localparam logic [2:0] COL_BITS = 3'b010;  // hcnt[8:6]

    // two hex digits on pixels 208..223
    localparam logic [4:0] COL_HEX  = 5'b01101;  // hcnt[8:4]

endpackage

`default_nettype wire

// ==== list.f ====
debug_key_pkg.sv
debug_video_pkg.sv
debug_font.sv
debug_keys.sv
debug_raster.sv
debug_overlay.sv
debug_top.sv
debug_chk.sv
tb_debug_top.sv

// ==== tb_debug_top.sv ====
////////////////////////////////////////////////////////////////////////////
// directed testbench for debug_top; colours sampled at cell offsets 1 and 2
// frames run just past the view row, so one frame is 216 active lines
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_debug_top import debug_key_pkg::*, debug_video_pkg::*; ();

    localparam int COLORW = 4;
    typedef logic [COLORW-1:0] color_t;

    logic        clk, rst, shift, ctrl, debug_plus, debug_minus;
    logic        pxl_cen, lhbl, lvbl;
    gfx_en_t     key_gfx, gfx_en;
    key_digit_t  key_digit;
    color_t      rin, gin, bin, rout, gout, bout;
    dbg_byte_t   debug_bus, debug_view, sys_info;

    int          errors, checks;
    logic [31:0] lcg;
    raster_cnt_t hc, vc;       // own copy of the beam counters
    logic        hb_l;
    dbg_byte_t   exp_bus, exp_view;
    gfx_en_t     exp_gfx;
    logic        exp_vsel;

    debug_top #(.COLORW(COLORW)) DUT (
        .clk (clk), .rst (rst), .shift (shift), .ctrl (ctrl),
        .debug_plus (debug_plus), .debug_minus (debug_minus),
        .key_gfx (key_gfx), .key_digit (key_digit), .pxl_cen (pxl_cen),
        .rin (rin), .gin (gin), .bin (bin), .lhbl (lhbl), .lvbl (lvbl),
        .rout (rout), .gout (gout), .bout (bout), .debug_bus (debug_bus),
        .debug_view (debug_view), .sys_info (sys_info), .gfx_en (gfx_en)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #40_000_000;
        $display("timeout, the tests did not finish within 40 ms");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic dbg_byte_t reverse_bits(input dbg_byte_t v);
        dbg_byte_t r;
        for (int i = 0; i < 8; i++) begin
            r[i] = v[7-i];
        end
        return r;
    endfunction

    // what the overlay should show at the current hc/vc
    function automatic color_t expect_color(input color_t c);
        color_t     e;
        logic [2:0] k;
        e = c;
        k = hc[5:3];  // leftmost bit cell shows bit 7
        if (vc[8:3] == ROW_BUS && exp_bus != 8'h00) begin
            if (hc[8:6] == COL_BITS)
                e = {COLORW{exp_bus[3'd7 - k]}};
            else if (hc[8:4] == COL_HEX)
                e[COLORW-1 -: 2] = 2'b11;
        end
        if (vc[8:3] == ROW_VIEW) begin
            if (hc[8:6] == COL_BITS && exp_view != 8'h00)
                e[COLORW-1 -: 2] = {2{exp_view[3'd7 - k]}};
            else if (hc[8:4] == COL_HEX && (exp_view != 8'h00 || exp_vsel))
                e[COLORW-1 -: 2] = 2'b11;
        end
        return e;
    endfunction

    task automatic check_byte(input string name, input dbg_byte_t got, input dbg_byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_gfx(input string name, input gfx_en_t got, input gfx_en_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_color(input string name, input color_t got, input color_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h at h %0d v %0d",
                     name, got, exp, hc, vc);
        end
    endtask

    task automatic report(input string name);
        $display("%s finished, %0d checks, %0d errors so far", name, checks, errors);
    endtask

    task automatic set_keys(input logic s, input logic c, input logic p, input logic m,
                            input gfx_en_t g, input key_digit_t d);
        shift       = s;
        ctrl        = c;
        debug_plus  = p;
        debug_minus = m;
        key_gfx     = g;
        key_digit   = d;
    endtask

    // keys held for ten cycles still act only once
    task automatic press(input logic s, input logic c, input logic p, input logic m,
                         input gfx_en_t g, input key_digit_t d);
        set_keys(s, c, p, m, g, d);
        repeat (10) @(negedge clk);
        set_keys(1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
        @(negedge clk);
    endtask

    task automatic key_step(input logic s, input logic up);
        dbg_byte_t amount;
        amount = s ? 8'd16 : 8'd1;
        press(s, 1'b0, up, ~up, '0, '0);
        exp_bus = up ? exp_bus + amount : exp_bus - amount;
        check_byte("debug_bus", debug_bus, exp_bus);
    endtask

    // one pixel with pxl_cen high for a clk then low for a clk
    task automatic pixel(input logic hb, input logic vb);
        lcg     = lcg_next(lcg);
        pxl_cen = 1'b1;
        lhbl    = hb;
        lvbl    = vb;
        rin     = lcg[31 -: COLORW];
        gin     = lcg[23 -: COLORW];
        bin     = lcg[15 -: COLORW];
        @(posedge clk);
        if (!vb)
            vc = '0;
        else if (hb && !hb_l)
            vc = vc + raster_cnt_t'(1);
        hb_l = hb;
        hc   = hb ? hc + raster_cnt_t'(1) : '0;
        @(negedge clk);
        if (hc[2:0] == 3'd1 || hc[2:0] == 3'd2) begin
            check_color("rout", rout, expect_color(rin));
            check_color("gout", gout, expect_color(gin));
            check_color("bout", bout, expect_color(bin));
        end
        pxl_cen = 1'b0;
        @(negedge clk);
    endtask

    task automatic frame();
        int lines;
        repeat (4) pixel(1'b0, 1'b0);  // vertical blank
        lines = 0;
        while (vc < 9'd216 && lines < 300) begin
            repeat (8) pixel(1'b0, 1'b1);
            repeat (512) pixel(1'b1, 1'b1);
            lines++;
        end
        if (lines >= 300) begin
            errors++;
            $display("frame never got past the view row");
        end
    endtask

    task automatic test_steps();
        check_byte("debug_bus", debug_bus, 8'h00);
        check_gfx("gfx_en", gfx_en, 4'hF);
        key_step(1'b0, 1'b1);
        key_step(1'b1, 1'b1);
        key_step(1'b0, 1'b0);
        key_step(1'b1, 1'b0);
        key_step(1'b0, 1'b0);   // wraps to ff
        key_step(1'b1, 1'b1);
        report("test_steps");
    endtask

    task automatic test_clear_xor();
        press(1'b0, 1'b1, 1'b1, 1'b0, '0, '0);
        exp_bus = 8'h00;
        check_byte("debug_bus", debug_bus, exp_bus);
        press(1'b1, 1'b0, 1'b0, 1'b0, '0, 8'h01);
        exp_bus = exp_bus ^ reverse_bits(8'h01);
        check_byte("debug_bus", debug_bus, exp_bus);
        press(1'b1, 1'b0, 1'b1, 1'b0, '0, 8'h06);  // XOR beats the step
        exp_bus = exp_bus ^ reverse_bits(8'h06);
        check_byte("debug_bus", debug_bus, exp_bus);
        press(1'b0, 1'b1, 1'b0, 1'b1, '0, '0);
        exp_bus = 8'h00;
        check_byte("debug_bus", debug_bus, exp_bus);
        report("test_clear_xor");
    endtask

    task automatic test_gfx();
        logic [1:0] b;
        for (int i = 0; i < 8; i++) begin
            b = 2'(i);
            press(1'b0, 1'b0, 1'b0, 1'b0, 4'b0001 << b, '0);
            exp_gfx[b] = ~exp_gfx[b];
            check_gfx("gfx_en", gfx_en, exp_gfx);
        end
        report("test_gfx");
    endtask

    task automatic test_passthrough();
        frame();
        report("test_passthrough");
    endtask

    task automatic test_bus_row();
        debug_view = 8'h81;
        exp_view   = 8'h81;
        press(1'b1, 1'b0, 1'b0, 1'b0, '0, reverse_bits(8'hA6));
        exp_bus = 8'hA6;
        check_byte("debug_bus", debug_bus, exp_bus);
        frame();
        report("test_bus_row");
    endtask

    task automatic test_view_select();
        sys_info = 8'h00;
        press(1'b1, 1'b1, 1'b0, 1'b0, '0, '0);
        exp_vsel = 1'b1;
        exp_view = 8'h00;
        check_byte("debug_bus", debug_bus, exp_bus);
        frame();                // hex drawn with a zero view
        sys_info = 8'h5A;
        exp_view = 8'h5A;
        frame();
        report("test_view_select");
    endtask

    initial begin
        errors = 0;
        checks = 0;
        lcg    = 32'hd8996e7e;
        rst    = 1'b1;
        set_keys(1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
        {pxl_cen, lhbl, lvbl} = 3'b000;
        {rin, gin, bin} = '0;
        debug_view = 8'h00;
        sys_info   = 8'h00;
        {hc, vc, hb_l} = '0;
        {exp_bus, exp_view, exp_vsel} = '0;
        exp_gfx = 4'hF;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_steps();
        test_clear_xor();
        test_gfx();
        test_passthrough();
        test_bus_row();
        test_view_select();
        errors = errors + DUT.u_chk.fail_cnt;
        $display("done, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
